/* Makefile */
VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= ex_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test OK
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh verification/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* ex_stage.f */
+incdir+logic
logic/mips_isa_pkg.sv
logic/ex_pipe_pkg.sv
logic/ex_issue_if.sv
logic/ex_result_if.sv
logic/ex_operand_latch.sv
logic/alu_core.sv
logic/ex_writeback.sv
logic/ex_stage.sv
verification/tb_clock_gen.sv
verification/ex_stage_tb.sv

/* logic/alu_core.sv */
`default_nettype none

`include "ex_macros.svh"

module alu_core
	import mips_isa_pkg::*;
	import ex_pipe_pkg::*;
(
	ex_issue_if.dst  issue,
	ex_result_if.src res
);

	localparam int SH_W = $clog2(`EX_XLEN);

	logic [`EX_XLEN-1:0]  op_a;
	logic [`EX_XLEN-1:0]  op_b;
	logic [SH_W-1:0]      sh_imm;
	logic [SH_W-1:0]      sh_var;
	logic                 lt_signed;
	logic                 lt_unsigned;
	logic [`EX_XLEN-1:0]  result;
	ex_result_t           res_next;

	assign op_a   = issue.payload.op_a;
	assign op_b   = issue.payload.op_b;
	assign sh_imm = issue.payload.shamt;

	// Variable shifts only look at the low bits of rs
	assign sh_var = op_a[SH_W-1:0];

	assign lt_signed   = $signed(op_a) < $signed(op_b);
	assign lt_unsigned = op_a < op_b;

	////////////////////////////////////////
	// Result select
	////////////////////////////////////////

	always_comb
	begin
		case (issue.payload.code)
			// Shifts, value always comes from rt
			ALU_SLL:  result = op_b << sh_imm;
			ALU_SRL:  result = op_b >> sh_imm;
			ALU_SRA:  result = $signed(op_b) >>> sh_imm;
			ALU_SLLV: result = op_b << sh_var;
			ALU_SRLV: result = op_b >> sh_var;
			ALU_SRAV: result = $signed(op_b) >>> sh_var;

			// No overflow traps, so the signed forms wrap like the unsigned ones
			ALU_ADD, ALU_ADDU, ALU_ADDI, ALU_ADDIU:
				result = op_a + op_b;
			ALU_SUB, ALU_SUBU:
				result = op_a - op_b;

			// Immediate already zero extended on the input side
			ALU_AND, ALU_ANDI: result = op_a & op_b;
			ALU_OR, ALU_ORI:   result = op_a | op_b;
			ALU_XOR, ALU_XORI: result = op_a ^ op_b;
			ALU_NOR:           result = ~(op_a | op_b);

			ALU_SLT, ALU_SLTI:
				result = {{(`EX_XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU, ALU_SLTIU:
				result = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};

			ALU_LUI:
				result = {op_b[`EX_IMM_W-1:0], {(`EX_XLEN-`EX_IMM_W){1'b0}}};

			// Return address as the stage sees it
			ALU_LINK:
				result = {{(`EX_XLEN-`EX_PC_W){1'b0}}, issue.payload.pc};

			default:
				result = '1;
		endcase
	end

	////////////////////////////////////////
	// Hand over to the output side
	////////////////////////////////////////

	always_comb
	begin
		res_next.result = result;
		res_next.dest   = issue.payload.dest;
		res_next.branch = issue.payload.branch;
	end

	assign res.valid   = issue.valid;
	assign res.payload = res_next;

	// Input side must never present a partly loaded instruction
	a_payload_known: assert property (@(posedge issue.clk)
		issue.valid |-> !$isunknown(issue.payload));

endmodule

`default_nettype wire

/* logic/ex_issue_if.sv */
`default_nettype none

interface ex_issue_if
	import ex_pipe_pkg::*;
(
	input logic clk
);

	logic      valid;
	// Only meaningful while valid is high
	ex_issue_t payload;

	modport src
	(
		output valid,
		output payload
	);

	// Clock comes along so the combinational reader can check its input
	modport dst
	(
		input clk,
		input valid,
		input payload
	);

endinterface

`default_nettype wire

/* logic/ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Datapath width of the execute stage
`define EX_XLEN 32

// Program counter bits that reach the stage
`define EX_PC_W 11

// Register file index
`define EX_REG_W 5

// Immediate field of I-type instructions
`define EX_IMM_W 16

`endif

/* logic/ex_operand_latch.sv */
`default_nettype none

`include "ex_macros.svh"

module ex_operand_latch
	import mips_isa_pkg::*;
	import ex_pipe_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         issue_valid,
	input  alu_class_t                   alu_class,
	input  alu_code_t                    operation,
	input  logic                         use_imm,
	input  logic [`EX_XLEN-1:0]          rs_value,
	input  logic [`EX_XLEN-1:0]          rt_value,
	input  logic [`EX_IMM_W-1:0]         imm,
	input  logic [$clog2(`EX_XLEN)-1:0]  shamt,
	input  logic [`EX_PC_W-1:0]          pc,
	input  logic [`EX_REG_W-1:0]         dest,
	input  branch_kind_t                 branch_kind,
	ex_issue_if.src                      issue
);

	alu_code_t            code_eff;
	logic                 zero_ext;
	logic [`EX_XLEN-1:0]  imm_ext;
	ex_issue_t            issue_next;

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////

	// Class overrides the operation field except for by-code
	always_comb
	begin
		case (alu_class)
			ALU_CLASS_ADD:  code_eff = ALU_ADD;
			ALU_CLASS_SUB:  code_eff = ALU_SUB;
			ALU_CLASS_CODE: code_eff = operation;
			default:        code_eff = ALU_LINK;
		endcase
	end

	// Logical immediates are zero extended, all others sign extended
	assign zero_ext = (code_eff == ALU_ANDI) || (code_eff == ALU_ORI) || (code_eff == ALU_XORI);

	assign imm_ext = zero_ext ?
		{{(`EX_XLEN-`EX_IMM_W){1'b0}}, imm} :
		{{(`EX_XLEN-`EX_IMM_W){imm[`EX_IMM_W-1]}}, imm};

	always_comb
	begin
		issue_next.code   = code_eff;
		issue_next.op_a   = rs_value;
		issue_next.op_b   = use_imm ? imm_ext : rt_value;
		issue_next.shamt  = shamt;
		issue_next.pc     = pc;
		issue_next.dest   = dest;
		issue_next.branch = branch_kind;
	end

	////////////////////////////////////////
	// Issue register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			issue.valid <= 1'b0;
		else
			issue.valid <= issue_valid;
	end

	always_ff @(posedge clk)
	begin
		if (issue_valid)
			issue.payload <= issue_next;
	end

	// A link never doubles as a branch compare
	a_link_not_branch: assert property (@(posedge clk) disable iff (!rst_n)
		issue.valid |-> (issue.payload.code != ALU_LINK || issue.payload.branch == BR_NONE));

endmodule

`default_nettype wire

/* logic/ex_pipe_pkg.sv */
`default_nettype none

`include "ex_macros.svh"

package ex_pipe_pkg;

	import mips_isa_pkg::*;

	// Decoded instruction held by the input side
	typedef struct packed
	{
		alu_code_t                    code;
		logic [`EX_XLEN-1:0]          op_a;
		logic [`EX_XLEN-1:0]          op_b;
		logic [$clog2(`EX_XLEN)-1:0]  shamt;
		logic [`EX_PC_W-1:0]          pc;
		logic [`EX_REG_W-1:0]         dest;
		branch_kind_t                 branch;
	} ex_issue_t;

	// Value leaving the processing part
	typedef struct packed
	{
		logic [`EX_XLEN-1:0]   result;
		logic [`EX_REG_W-1:0]  dest;
		branch_kind_t          branch;
	} ex_result_t;

endpackage

`default_nettype wire

/* logic/ex_result_if.sv */
`default_nettype none

interface ex_result_if
	import ex_pipe_pkg::*;
();

	logic       valid;
	ex_result_t payload;

	modport src
	(
		output valid,
		output payload
	);

	modport dst
	(
		input valid,
		input payload
	);

endinterface

`default_nettype wire

/* logic/ex_stage.sv */
`default_nettype none

`include "ex_macros.svh"

module ex_stage
	import mips_isa_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         issue_valid,
	input  alu_class_t                   alu_class,
	input  alu_code_t                    operation,
	input  logic                         use_imm,
	input  logic [`EX_XLEN-1:0]          rs_value,
	input  logic [`EX_XLEN-1:0]          rt_value,
	input  logic [`EX_IMM_W-1:0]         imm,
	input  logic [$clog2(`EX_XLEN)-1:0]  shamt,
	input  logic [`EX_PC_W-1:0]          pc,
	input  logic [`EX_REG_W-1:0]         dest,
	input  branch_kind_t                 branch_kind,
	output logic                         result_valid,
	output logic [`EX_XLEN-1:0]          result,
	output logic [`EX_REG_W-1:0]         result_dest,
	output logic                         zero,
	output logic                         branch_taken
);

	ex_issue_if  issue_bus (.clk(clk));
	ex_result_if res_bus ();

	// Edge N, operands and effective code
	ex_operand_latch u_operand_latch
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.alu_class   (alu_class),
		.operation   (operation),
		.use_imm     (use_imm),
		.rs_value    (rs_value),
		.rt_value    (rt_value),
		.imm         (imm),
		.shamt       (shamt),
		.pc          (pc),
		.dest        (dest),
		.branch_kind (branch_kind),
		.issue       (issue_bus.src)
	);

	alu_core u_alu_core
	(
		.issue (issue_bus.dst),
		.res   (res_bus.src)
	);

	// Edge N+1, result and branch decision
	ex_writeback u_writeback
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.res          (res_bus.dst),
		.result_valid (result_valid),
		.result       (result),
		.result_dest  (result_dest),
		.zero         (zero),
		.branch_taken (branch_taken)
	);

endmodule

`default_nettype wire

/* logic/ex_writeback.sv */
`default_nettype none

`include "ex_macros.svh"

module ex_writeback
	import mips_isa_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	ex_result_if.dst              res,
	output logic                  result_valid,
	output logic [`EX_XLEN-1:0]   result,
	output logic [`EX_REG_W-1:0]  result_dest,
	output logic                  zero,
	output logic                  branch_taken
);

	logic zero_next;
	logic taken_next;

	assign zero_next = (res.payload.result == '0);

	// BEQ and BNE both compare through the subtract result
	always_comb
	begin
		case (res.payload.branch)
			BR_EQ:   taken_next = zero_next;
			BR_NE:   taken_next = !zero_next;
			default: taken_next = 1'b0;
		endcase
	end

	// Data outputs hold, strobes drop when nothing arrives
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			result_valid <= 1'b0;
			branch_taken <= 1'b0;
			result       <= '0;
			result_dest  <= '0;
			zero         <= 1'b1;
		end
		else
		begin
			result_valid <= res.valid;
			branch_taken <= res.valid && taken_next;
			if (res.valid)
			begin
				result      <= res.payload.result;
				result_dest <= res.payload.dest;
				zero        <= zero_next;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

	// Operation class from the main decoder
	typedef enum logic [1:0]
	{
		ALU_CLASS_ADD  = 2'b00,
		ALU_CLASS_SUB  = 2'b01,
		ALU_CLASS_CODE = 2'b10,
		ALU_CLASS_LINK = 2'b11
	} alu_class_t;

	// Effective operation, R-type funct codes and I-type opcodes share one space
	typedef enum logic [5:0]
	{
		ALU_SLL   = 6'b000000,
		ALU_SRL   = 6'b000010,
		ALU_SRA   = 6'b000011,
		ALU_SLLV  = 6'b000100,
		ALU_SRLV  = 6'b000110,
		ALU_SRAV  = 6'b000111,
		ALU_ADDI  = 6'b001000,
		ALU_ADDIU = 6'b001001,
		ALU_SLTI  = 6'b001010,
		ALU_SLTIU = 6'b001011,
		ALU_ANDI  = 6'b001100,
		ALU_ORI   = 6'b001101,
		ALU_XORI  = 6'b001110,
		ALU_LUI   = 6'b001111,
		ALU_ADD   = 6'b100000,
		ALU_ADDU  = 6'b100001,
		ALU_SUB   = 6'b100010,
		ALU_SUBU  = 6'b100011,
		ALU_AND   = 6'b100100,
		ALU_OR    = 6'b100101,
		ALU_XOR   = 6'b100110,
		ALU_NOR   = 6'b100111,
		ALU_SLT   = 6'b101010,
		ALU_SLTU  = 6'b101011,
		// Internal only, taken from an unused opcode
		ALU_LINK  = 6'b110011
	} alu_code_t;

	typedef enum logic [1:0]
	{
		BR_NONE = 2'b00,
		BR_EQ   = 2'b01,
		BR_NE   = 2'b10
	} branch_kind_t;

endpackage

`default_nettype wire

/* verification/ex_stage_tb.sv */
`default_nettype none

`include "ex_macros.svh"

module ex_stage_tb
	import mips_isa_pkg::*;
();

	localparam int DRIVE_DELAY   = 2;
	localparam int RESET_CYCLES  = 4;
	localparam int RAND_PER_CODE = 12;
	localparam int BURST_LEN     = 8;
	// Tests need about 450 cycles
	localparam int MAX_CYCLES    = 1000;

	localparam alu_code_t RTYPE_CODES [16] = '{
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV,
		ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
	};

	logic                         clk;
	logic                         rst_n;
	logic                         issue_valid;
	alu_class_t                   alu_class;
	alu_code_t                    operation;
	logic                         use_imm;
	logic [`EX_XLEN-1:0]          rs_value;
	logic [`EX_XLEN-1:0]          rt_value;
	logic [`EX_IMM_W-1:0]         imm;
	logic [4:0]                   shamt;
	logic [`EX_PC_W-1:0]          pc;
	logic [`EX_REG_W-1:0]         dest;
	branch_kind_t                 branch_kind;
	logic                         result_valid;
	logic [`EX_XLEN-1:0]          result;
	logic [`EX_REG_W-1:0]         result_dest;
	logic                         zero;
	logic                         branch_taken;

	integer seed;
	int     cycle_count = 0;

	tb_clock_gen u_clock_gen (.clk(clk));

	ex_stage UUT
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.issue_valid  (issue_valid),
		.alu_class    (alu_class),
		.operation    (operation),
		.use_imm      (use_imm),
		.rs_value     (rs_value),
		.rt_value     (rt_value),
		.imm          (imm),
		.shamt        (shamt),
		.pc           (pc),
		.dest         (dest),
		.branch_kind  (branch_kind),
		.result_valid (result_valid),
		.result       (result),
		.result_dest  (result_dest),
		.zero         (zero),
		.branch_taken (branch_taken)
	);

	////////////////////////////////////////
	// Reporting
	////////////////////////////////////////

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			report_failure($sformatf("ERR time %0t %s: got 0x%08h, expected 0x%08h",
				$time, name, actual, expected));
	endtask

	// Watchdog over the whole run
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
			report_failure($sformatf("Timeout: the run did not end within %0d cycles",
				MAX_CYCLES));
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic logic [`EX_XLEN-1:0] rand32();
		return $random(seed);
	endfunction

	function automatic logic [31:0] shift_right_arith(input logic [31:0] value,
		input logic [4:0] amount);
		logic [31:0] fill;
		fill = value[31] ? ~(32'hffff_ffff >> amount) : 32'h0;
		return (value >> amount) | fill;
	endfunction

	function automatic logic [`EX_XLEN-1:0] expected_result(
		input alu_class_t            cls,
		input alu_code_t             op,
		input logic                  imm_sel,
		input logic [`EX_XLEN-1:0]   a,
		input logic [`EX_XLEN-1:0]   rt,
		input logic [`EX_IMM_W-1:0]  imm_in,
		input logic [4:0]            sa,
		input logic [`EX_PC_W-1:0]   pc_in
	);
		alu_code_t    code;
		logic [31:0]  b;
		logic [31:0]  r;
		logic         logical;
		if (cls == ALU_CLASS_ADD)
			code = ALU_ADD;
		else if (cls == ALU_CLASS_SUB)
			code = ALU_SUB;
		else if (cls == ALU_CLASS_LINK)
			code = ALU_LINK;
		else
			code = op;
		logical = (code == ALU_ANDI) || (code == ALU_ORI) || (code == ALU_XORI);
		if (!imm_sel)
			b = rt;
		else if (logical)
			b = {16'h0000, imm_in};
		else
			b = {{16{imm_in[15]}}, imm_in};
		case (code)
			ALU_SLL:                                r = b << sa;
			ALU_SRL:                                r = b >> sa;
			ALU_SRA:                                r = shift_right_arith(b, sa);
			ALU_SLLV:                               r = b << a[4:0];
			ALU_SRLV:                               r = b >> a[4:0];
			ALU_SRAV:                               r = shift_right_arith(b, a[4:0]);
			ALU_ADD, ALU_ADDU, ALU_ADDI, ALU_ADDIU: r = a + b;
			ALU_SUB, ALU_SUBU:                      r = a + ~b + 32'd1;
			ALU_AND, ALU_ANDI:                      r = a & b;
			ALU_OR, ALU_ORI:                        r = a | b;
			ALU_XOR, ALU_XORI:                      r = a ^ b;
			ALU_NOR:                                r = ~a & ~b;
			// Flipping the sign bits turns a signed compare into an unsigned one
			ALU_SLT, ALU_SLTI:
				r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
			ALU_SLTU, ALU_SLTIU:
				r = (a < b) ? 32'd1 : 32'd0;
			ALU_LUI:                                r = {b[15:0], 16'h0000};
			ALU_LINK:                               r = {21'h0, pc_in};
			default:                                r = 32'hffff_ffff;
		endcase
		return r;
	endfunction

	function automatic logic expected_taken(input branch_kind_t kind,
		input logic [`EX_XLEN-1:0] r);
		case (kind)
			BR_EQ:   return r == 32'd0;
			BR_NE:   return r != 32'd0;
			default: return 1'b0;
		endcase
	endfunction

	////////////////////////////////////////
	// Drivers
	////////////////////////////////////////

	task automatic drive_issue(
		input alu_class_t            cls,
		input alu_code_t             op,
		input logic                  imm_sel,
		input logic [`EX_XLEN-1:0]   a,
		input logic [`EX_XLEN-1:0]   b,
		input logic [`EX_IMM_W-1:0]  imm_in,
		input logic [4:0]            sa,
		input logic [`EX_PC_W-1:0]   pc_in,
		input logic [`EX_REG_W-1:0]  dest_in,
		input branch_kind_t          kind
	);
		issue_valid = 1'b1;
		alu_class   = cls;
		operation   = op;
		use_imm     = imm_sel;
		rs_value    = a;
		rt_value    = b;
		imm         = imm_in;
		shamt       = sa;
		pc          = pc_in;
		dest        = dest_in;
		branch_kind = kind;
	endtask

	// Called a short delay after a rising edge, returns at the same point two edges on
	task automatic execute_and_check(
		input alu_class_t            cls,
		input alu_code_t             op,
		input logic                  imm_sel,
		input logic [`EX_XLEN-1:0]   a,
		input logic [`EX_XLEN-1:0]   b,
		input logic [`EX_IMM_W-1:0]  imm_in,
		input logic [4:0]            sa,
		input logic [`EX_PC_W-1:0]   pc_in,
		input logic [`EX_REG_W-1:0]  dest_in,
		input branch_kind_t          kind
	);
		logic [31:0] exp_result;
		logic        exp_taken;
		exp_result = expected_result(cls, op, imm_sel, a, b, imm_in, sa, pc_in);
		exp_taken  = expected_taken(kind, exp_result);
		drive_issue(cls, op, imm_sel, a, b, imm_in, sa, pc_in, dest_in, kind);
		@(posedge clk);
		#DRIVE_DELAY;
		issue_valid = 1'b0;
		@(posedge clk);
		#DRIVE_DELAY;
		check_value("result_valid", 32'(result_valid), 32'd1);
		check_value("result", result, exp_result);
		check_value("result_dest", 32'(result_dest), 32'(dest_in));
		check_value("zero", 32'(zero), 32'(exp_result == 32'd0));
		check_value("branch_taken", 32'(branch_taken), 32'(exp_taken));
	endtask

	// By-code instruction without a branch
	task automatic issue_code(
		input alu_code_t             op,
		input logic                  imm_sel,
		input logic [`EX_XLEN-1:0]   a,
		input logic [`EX_XLEN-1:0]   b,
		input logic [`EX_IMM_W-1:0]  imm_in
	);
		execute_and_check(ALU_CLASS_CODE, op, imm_sel, a, b, imm_in, 5'd9, 11'h2c4, 5'd17,
			BR_NONE);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic reset_state_check();
		check_value("result_valid", 32'(result_valid), 32'd0);
		check_value("branch_taken", 32'(branch_taken), 32'd0);
		check_value("result", result, 32'd0);
		@(posedge clk);
		#DRIVE_DELAY;
		check_value("result_valid", 32'(result_valid), 32'd0);
	endtask

	task automatic rtype_sweep();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sel;
		for (int c = 0; c < 16; c++)
		begin
			for (int k = 0; k < RAND_PER_CODE; k++)
			begin
				a   = rand32();
				b   = rand32();
				sel = rand32();
				execute_and_check(ALU_CLASS_CODE, RTYPE_CODES[c], 1'b0, a, b, sel[31:16],
					sel[4:0], sel[15:5], sel[20:16], BR_NONE);
			end
		end
		// Signed and unsigned compares disagree on a negative operand
		issue_code(ALU_SLT, 1'b0, 32'hffff_fffb, 32'd3, 16'h0);
		check_value("result", result, 32'd1);
		issue_code(ALU_SLTU, 1'b0, 32'hffff_fffb, 32'd3, 16'h0);
		check_value("result", result, 32'd0);
		issue_code(ALU_SLT, 1'b0, 32'd3, 32'hffff_fffb, 16'h0);
		issue_code(ALU_SLTU, 1'b0, 32'd3, 32'hffff_fffb, 16'h0);
		issue_code(alu_code_t'(6'b111111), 1'b0, rand32(), rand32(), 16'h0);
		check_value("result", result, 32'hffff_ffff);
		issue_code(alu_code_t'(6'b010000), 1'b0, rand32(), rand32(), 16'h0);
	endtask

	task automatic immediate_extension();
		issue_code(ALU_ADDI, 1'b1, 32'd100, rand32(), 16'hfff6);
		check_value("result", result, 32'd90);
		issue_code(ALU_ADDIU, 1'b1, rand32(), rand32(), 16'h8001);
		issue_code(ALU_ANDI, 1'b1, 32'hffff_ffff, rand32(), 16'h8f0f);
		check_value("result", result, 32'h0000_8f0f);
		issue_code(ALU_ORI, 1'b1, 32'h1234_0000, rand32(), 16'h8000);
		issue_code(ALU_XORI, 1'b1, 32'hffff_0000, rand32(), 16'hffff);
		issue_code(ALU_SLTI, 1'b1, 32'hffff_fffe, rand32(), 16'hffff);
		issue_code(ALU_SLTIU, 1'b1, 32'd5, rand32(), 16'hffff);
		issue_code(ALU_LUI, 1'b1, rand32(), rand32(), 16'hbeef);
		check_value("result", result, 32'hbeef_0000);
	endtask

	task automatic class_override();
		execute_and_check(ALU_CLASS_ADD, ALU_SUB, 1'b0, 32'd7, 32'd5, 16'h0, 5'd0, 11'h0,
			5'd2, BR_NONE);
		check_value("result", result, 32'd12);
		execute_and_check(ALU_CLASS_ADD, ALU_NOR, 1'b1, rand32(), rand32(), 16'hff80, 5'd3,
			11'h0, 5'd4, BR_NONE);
		execute_and_check(ALU_CLASS_LINK, ALU_AND, 1'b0, rand32(), rand32(), 16'h0, 5'd0,
			11'h5a3, 5'd31, BR_NONE);
		check_value("result", result, 32'h0000_05a3);
		execute_and_check(ALU_CLASS_SUB, ALU_OR, 1'b0, 32'd20, 32'd30, 16'h0, 5'd0, 11'h0,
			5'd6, BR_NONE);
	endtask

	task automatic branch_decision();
		logic [31:0] a;
		logic [31:0] b;
		a = rand32();
		b = a ^ 32'h0000_0100;
		execute_and_check(ALU_CLASS_SUB, ALU_SLL, 1'b0, a, a, 16'h0, 5'd0, 11'h10, 5'd0, BR_EQ);
		check_value("branch_taken", 32'(branch_taken), 32'd1);
		execute_and_check(ALU_CLASS_SUB, ALU_SLL, 1'b0, a, b, 16'h0, 5'd0, 11'h11, 5'd0, BR_EQ);
		execute_and_check(ALU_CLASS_SUB, ALU_SLL, 1'b0, a, a, 16'h0, 5'd0, 11'h12, 5'd0, BR_NE);
		execute_and_check(ALU_CLASS_SUB, ALU_SLL, 1'b0, a, b, 16'h0, 5'd0, 11'h13, 5'd0, BR_NE);
		check_value("branch_taken", 32'(branch_taken), 32'd1);
		execute_and_check(ALU_CLASS_SUB, ALU_SLL, 1'b0, a, a, 16'h0, 5'd0, 11'h14, 5'd0,
			BR_NONE);
	endtask

	// One issue per cycle, each result shows up two edges after its issue
	task automatic back_to_back_burst();
		logic [31:0]  exp_q [$];
		logic [4:0]   dest_q [$];
		logic [31:0]  a;
		logic [31:0]  b;
		logic [31:0]  sel;
		alu_class_t   cls;
		alu_code_t    op;
		for (int i = 0; i < BURST_LEN + 2; i++)
		begin
			if (i < BURST_LEN)
			begin
				a   = rand32();
				b   = rand32();
				sel = rand32();
				cls = alu_class_t'(sel[1:0]);
				op  = RTYPE_CODES[sel[5:2]];
				exp_q.push_back(expected_result(cls, op, sel[6], a, b, sel[31:16], sel[11:7],
					sel[22:12]));
				dest_q.push_back(sel[27:23]);
				drive_issue(cls, op, sel[6], a, b, sel[31:16], sel[11:7], sel[22:12],
					sel[27:23], BR_NONE);
			end
			else
				issue_valid = 1'b0;
			if (i >= 2)
			begin
				check_value("result_valid", 32'(result_valid), 32'd1);
				check_value("result", result, exp_q.pop_front());
				check_value("result_dest", 32'(result_dest), 32'(dest_q.pop_front()));
			end
			@(posedge clk);
			#DRIVE_DELAY;
		end
		check_value("result_valid", 32'(result_valid), 32'd0);
		check_value("branch_taken", 32'(branch_taken), 32'd0);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		seed        = 32'h11db_4662;
		rst_n       = 1'b0;
		issue_valid = 1'b0;
		alu_class   = ALU_CLASS_ADD;
		operation   = ALU_SLL;
		use_imm     = 1'b0;
		rs_value    = '0;
		rt_value    = '0;
		imm         = '0;
		shamt       = '0;
		pc          = '0;
		dest        = '0;
		branch_kind = BR_NONE;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		reset_state_check();
		rtype_sweep();
		immediate_extension();
		class_override();
		branch_decision();
		back_to_back_burst();
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen
(
	output logic clk
);

	localparam int HALF_PERIOD = 10;

	// Free running, first rising edge at 10
	initial
	begin
		clk = 1'b0;
		forever
			#HALF_PERIOD clk = ~clk;
	end

endmodule

`default_nettype wire
